/* Bender.yml */
package:
  name: booth_multiplier

sources:
  - files:
      - hdl/booth_pkg.sv
      - hdl/booth_controller.sv
      - hdl/booth_alu.sv
      - hdl/booth_datapath.sv
      - hdl/booth_product.sv
      - hdl/booth_multiplier.sv
  - target: test
    files:
      - test/tb_booth_multiplier.sv

# Top levels: booth_multiplier (RTL), tb_booth_multiplier (simulation)

/* all.f */
hdl/booth_pkg.sv
hdl/booth_controller.sv
hdl/booth_alu.sv
hdl/booth_datapath.sv
hdl/booth_product.sv
hdl/booth_multiplier.sv
test/tb_booth_multiplier.sv

/* hdl/booth_alu.sv */
`timescale 1ns/1ps
`default_nettype none

// Execute arithmetic of the Booth multiplier
// Purely combinational, result consumed by the datapath shift
module booth_alu (
    input  logic [booth_pkg::OP_WIDTH-1:0] acc,      // Accumulator A
    input  logic [booth_pkg::OP_WIDTH-1:0] mcand,    // Multiplicand M
    input  booth_pkg::alu_op_t             alu_op,   // From controller
    output logic [booth_pkg::OP_WIDTH-1:0] alu_sum   // New A before shift
);

    import booth_pkg::*;

    // Overflow wraps; the arithmetic shift afterwards keeps the
    // running partial product within range
    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                alu_sum = acc + mcand;     // End of a run of ones
            end
            ALU_SUB: begin
                alu_sum = acc - mcand;     // Start of a run of ones
            end
            default: begin
                alu_sum = acc;             // Pass
            end
        endcase
    end

endmodule : booth_alu

`default_nettype wire

/* hdl/booth_controller.sv */
`timescale 1ns/1ps
`default_nettype none

// Decode stage of the Booth multiplier
// Two states, all outputs decoded combinationally from state and inputs
module booth_controller (
    input  logic              clk,        // System clock
    input  logic              rst_n,      // Async reset, active low
    input  logic              start,      // Level, sampled in IDLE only
    input  logic              count_done, // Step counter exhausted
    input  logic              q0,         // Low bit of Q
    input  logic              q_1,        // Extra bit right of Q
    output logic              load,       // Load operands, IDLE + start
    output logic              step,       // Add/sub then shift
    output logic              clear,      // Zero the datapath
    output logic              ready,      // Product valid this cycle
    output booth_pkg::alu_op_t alu_op,    // ALU operation select
    output logic              busy        // Multiplication in flight
);

    import booth_pkg::*;

    ctrl_state_t state;      // Current state
    ctrl_state_t state_nxt;  // Next state

    // State register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;         // Idle after reset
        end else begin
            state <= state_nxt;
        end
    end

    // Next state and strobe decode
    always_comb begin
        state_nxt = state;         // Hold by default
        load      = 1'b0;
        step      = 1'b0;
        clear     = 1'b0;
        ready     = 1'b0;
        alu_op    = ALU_PASS;      // No x outputs, pass when idle

        case (state)
            IDLE: begin
                if (start) begin
                    load      = 1'b1;      // Capture operands at this edge
                    state_nxt = RUN;
                end
            end

            RUN: begin
                if (count_done) begin
                    // All OP_WIDTH steps done, hand A:Q to the result stage
                    ready     = 1'b1;
                    clear     = 1'b1;      // Datapath zeroed at same edge
                    state_nxt = IDLE;
                end else begin
                    step = 1'b1;           // One Booth step per cycle
                    // Booth pair Q0,Q_1
                    case ({q0, q_1})
                        2'b10:   alu_op = ALU_SUB;   // A - M
                        2'b01:   alu_op = ALU_ADD;   // A + M
                        default: alu_op = ALU_PASS;  // 00 or 11, shift only
                    endcase
                end
            end

            default: begin
                state_nxt = IDLE;          // Recover from illegal state
            end
        endcase
    end

    assign busy = (state == RUN);  // High from load edge to finish edge

endmodule : booth_controller

`default_nettype wire

/* hdl/booth_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

// Execute registers of the Booth multiplier
// Holds M, A, Q, Q_1 and the step counter
module booth_datapath (
    input  logic                           clk,          // System clock
    input  logic                           rst_n,        // Async active-low reset
    input  logic                           load,         // Initialize from operands
    input  logic                           step,         // Take alu_sum and shift
    input  logic                           clear,        // Zero everything
    input  logic [booth_pkg::OP_WIDTH-1:0] multiplicand, // Operand M
    input  logic [booth_pkg::OP_WIDTH-1:0] multiplier,   // Operand Q
    input  logic [booth_pkg::OP_WIDTH-1:0] alu_sum,      // A op M from ALU
    output logic [booth_pkg::OP_WIDTH-1:0] acc,          // Accumulator A
    output logic [booth_pkg::OP_WIDTH-1:0] mcand,        // Registered M
    output logic [booth_pkg::OP_WIDTH-1:0] q,            // Multiplier / low product
    output logic                           q0,           // Q[0] for decode
    output logic                           q_1,          // Bit shifted out of Q
    output logic                           count_done    // Counter at zero
);

    import booth_pkg::*;

    logic [CNT_WIDTH-1:0] count;     // Remaining steps
    logic                 sum_ovf;   // A op M left the OP_WIDTH range
    logic                 sum_sign;  // Sign of A op M at OP_WIDTH+1 bits
    logic [OP_WIDTH-1:0]  acc_shft;  // alu_sum shifted right with its true sign
    logic [OP_WIDTH-1:0]  q_shft;    // Q shifted right under the sum LSB

    // Pair 10 subtracts M and pair 01 adds it
    assign sum_ovf  = (q[0] ^ q_1)                                    // Add or subtract step
                    & (acc[OP_WIDTH-1] ^ alu_sum[OP_WIDTH-1])         // Sign flipped
                    & ~(acc[OP_WIDTH-1] ^ mcand[OP_WIDTH-1] ^ q[0]);  // Like operand signs
    assign sum_sign = sum_ovf ? acc[OP_WIDTH-1] : alu_sum[OP_WIDTH-1]; // Undo the wrap

    // Arithmetic right shift of {A op M, q, q_1} by one
    assign acc_shft = {sum_sign, alu_sum[OP_WIDTH-1:1]};             // Sign fill
    assign q_shft   = {alu_sum[0], q[OP_WIDTH-1:1]};                 // Carry into Q

    // Counter and Q_1 register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            q_1   <= 1'b0;
        end else if (clear) begin
            count <= '0;
            q_1   <= 1'b0;
        end else if (load) begin
            count <= CNT_WIDTH'(OP_WIDTH);   // One step per operand bit
            q_1   <= 1'b0;                   // Implicit zero right of Q
        end else if (step) begin
            count <= count - 1'b1;
            q_1   <= q[0];                   // Q0 drops into Q_1
        end
    end

    // M, A and Q registers
    always_ff @(posedge clk) begin
        if (clear) begin
            mcand <= '0;
            acc   <= '0;
            q     <= '0;
        end else if (load) begin
            mcand <= multiplicand;
            acc   <= '0;                     // A starts at zero
            q     <= multiplier;
        end else if (step) begin
            acc   <= acc_shft;               // M unchanged during run
            q     <= q_shft;
        end
    end

    assign q0         = q[0];
    assign count_done = (count == '0);       // Also high in IDLE where it is ignored

endmodule : booth_datapath

`default_nettype wire

/* hdl/booth_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

// Sequential signed multiplier, radix-2 Booth
// OP_WIDTH+1 cycles from the start edge to done
module booth_multiplier (
    input  logic                             clk,          // System clock
    input  logic                             rst_n,        // Async reset, active low
    input  logic                             start,        // Level, ignored while busy
    input  logic [booth_pkg::OP_WIDTH-1:0]   multiplicand, // Signed operand M
    input  logic [booth_pkg::OP_WIDTH-1:0]   multiplier,   // Signed operand Q
    output logic                             busy,         // Multiplication in flight
    output logic                             done,         // One-cycle finish pulse
    output logic [booth_pkg::PROD_WIDTH-1:0] product       // Signed product, held
);

    logic                           load;        // Controller to datapath
    logic                           step;
    logic                           clear;
    logic                           ready;       // Controller to result stage
    logic                           q0;          // Datapath to controller
    logic                           q_1;
    logic                           count_done;
    booth_pkg::alu_op_t             alu_op;      // Controller to ALU
    logic [booth_pkg::OP_WIDTH-1:0] acc;         // A register
    logic [booth_pkg::OP_WIDTH-1:0] mcand;       // M register
    logic [booth_pkg::OP_WIDTH-1:0] q;           // Q register
    logic [booth_pkg::OP_WIDTH-1:0] alu_sum;     // ALU result

    booth_controller u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .count_done (count_done),
        .q0         (q0),
        .q_1        (q_1),
        .load       (load),
        .step       (step),
        .clear      (clear),
        .ready      (ready),
        .alu_op     (alu_op),
        .busy       (busy)
    );

    booth_datapath u_dp (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .step         (step),
        .clear        (clear),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .alu_sum      (alu_sum),
        .acc          (acc),
        .mcand        (mcand),
        .q            (q),
        .q0           (q0),
        .q_1          (q_1),
        .count_done   (count_done)
    );

    booth_alu u_alu (
        .acc     (acc),
        .mcand   (mcand),
        .alu_op  (alu_op),
        .alu_sum (alu_sum)
    );

    booth_product u_prod (
        .clk     (clk),
        .rst_n   (rst_n),
        .ready   (ready),
        .acc     (acc),
        .q       (q),
        .product (product),
        .done    (done)
    );

endmodule : booth_multiplier

`default_nettype wire

/* hdl/booth_pkg.sv */
`default_nettype none

// Shared widths and encodings for the radix-2 Booth multiplier
package booth_pkg;

    // Two's complement operand and product widths
    localparam int OP_WIDTH   = 8;                    // Multiplicand / multiplier bits
    localparam int PROD_WIDTH = 2 * OP_WIDTH;         // A:Q concatenation
    localparam int CNT_WIDTH  = $clog2(OP_WIDTH + 1); // Must hold OP_WIDTH itself

    // Controller states
    typedef enum logic {
        IDLE = 1'b0,    // Waiting for start
        RUN  = 1'b1     // Stepping through Booth pairs
    } ctrl_state_t;

    // ALU opcodes
    typedef enum logic [1:0] {
        ALU_PASS = 2'b00,   // Pair 00 or 11
        ALU_SUB  = 2'b01,   // Pair 10 starts a run of ones
        ALU_ADD  = 2'b10    // Pair 01 ends a run of ones
    } alu_op_t;

endpackage : booth_pkg

`default_nettype wire

/* hdl/booth_product.sv */
`timescale 1ns/1ps
`default_nettype none

// Result stage of the Booth multiplier
// Captures A:Q when ready pulses, holds it until the next finish
module booth_product (
    input  logic                             clk,     // System clock
    input  logic                             rst_n,   // Async reset, active low
    input  logic                             ready,   // Finish strobe from controller
    input  logic [booth_pkg::OP_WIDTH-1:0]   acc,     // High half of product
    input  logic [booth_pkg::OP_WIDTH-1:0]   q,       // Low half of product
    output logic [booth_pkg::PROD_WIDTH-1:0] product, // Signed result
    output logic                             done     // One cycle after capture
);

    // Product register, zero out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            product <= '0;
        end else if (ready) begin
            product <= {acc, q};   // A:Q before the datapath clears
        end
    end

    // Done follows ready by one edge, so it lasts exactly one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= ready;
        end
    end

endmodule : booth_product

`default_nettype wire

/* test/tb_booth_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

// Self-checking testbench for the radix-2 Booth multiplier
// Timing model on posedge and checker on negedge
module tb_booth_multiplier;

    import booth_pkg::*;

    logic                  clk = 1'b0;     // 40 ns clock
    logic                  rst_n;          // Async active-low reset
    logic                  start;          // Start level to DUT
    logic [OP_WIDTH-1:0]   multiplicand;   // Operand M
    logic [OP_WIDTH-1:0]   multiplier;     // Operand Q
    logic                  busy;           // DUT outputs
    logic                  done;
    logic [PROD_WIDTH-1:0] product;

    logic                  m_busy;         // Expected busy
    logic                  m_done;         // Expected done pulse
    logic [PROD_WIDTH-1:0] m_prod;         // Expected product output
    logic [PROD_WIDTH-1:0] m_pending;      // Product of accepted operands
    int                    m_steps;        // Edges since accept

    int err_busy    = 0;                   // Error counters per kind
    int err_done    = 0;
    int err_product = 0;
    int err_timeout = 0;
    int n_checks    = 0;                   // Assertions evaluated
    int n_mults     = 0;                   // Multiplications issued

    booth_multiplier uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .busy         (busy),
        .done         (done),
        .product      (product)
    );

    always #20 clk = ~clk;                 // 40 ns period

    // Full-width signed product of two operands
    function automatic logic [PROD_WIDTH-1:0] signed_product(
        input logic [OP_WIDTH-1:0] a,
        input logic [OP_WIDTH-1:0] b
    );
        logic signed [PROD_WIDTH-1:0] sa;
        logic signed [PROD_WIDTH-1:0] sb;
        sa = {{OP_WIDTH{a[OP_WIDTH-1]}}, a};   // Sign extend
        sb = {{OP_WIDTH{b[OP_WIDTH-1]}}, b};
        return sa * sb;                         // Always fits in PROD_WIDTH
    endfunction

    // Expected timing with OP_WIDTH+1 edges from accept to done
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_busy    <= 1'b0;
            m_done    <= 1'b0;
            m_prod    <= '0;
            m_pending <= '0;
            m_steps   <= 0;
        end else begin
            m_done <= 1'b0;                     // Pulse by default low
            if (!m_busy) begin
                if (start) begin
                    m_busy    <= 1'b1;          // Start edge k
                    m_steps   <= 0;
                    m_pending <= signed_product(multiplicand, multiplier);
                end
            end else if (m_steps == OP_WIDTH) begin
                m_busy <= 1'b0;                 // Finish edge k+OP_WIDTH+1
                m_done <= 1'b1;
                m_prod <= m_pending;            // Held until next finish
            end else begin
                m_steps <= m_steps + 1;         // Start ignored while busy
            end
        end
    end

    // Mid-cycle checker where all outputs have settled
    always @(negedge clk) begin
        n_checks = n_checks + 3;
        assert (busy === m_busy) else begin
            err_busy++;
            $display("FAIL %0t busy exp %0b act %0b", $time, m_busy, busy);
        end
        assert (done === m_done) else begin
            err_done++;
            $display("FAIL %0t done exp %0b act %0b", $time, m_done, done);
        end
        assert (product === m_prod) else begin
            err_product++;
            $display("FAIL %0t product exp %04h act %04h", $time, m_prod, product);
        end
    end

    // One-cycle start pulse that returns 2 ns after the sampling edge
    task automatic issue_start(input logic [OP_WIDTH-1:0] a, input logic [OP_WIDTH-1:0] b);
        @(posedge clk);
        #2;
        start        = 1'b1;
        multiplicand = a;
        multiplier   = b;
        @(posedge clk);                          // Edge k samples start
        #2;
        start        = 1'b0;
        n_mults++;
    endtask

    // Bounded poll of done that counts edges since the start edge
    task automatic wait_done(output int edges, output bit seen);
        int limit;
        limit = 4 * OP_WIDTH;                    // Generous bound
        edges = 0;                               // Just past edge k
        seen  = 1'b0;
        while (!seen && edges <= limit) begin
            if (done === 1'b1) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                #2;
                edges++;
            end
        end
        if (!seen) begin
            err_timeout++;
            $display("Timeout: done did not arrive within %0d cycles of start", limit);
        end
    endtask

    // Product on done against the operands that started the run
    task automatic check_result(input logic [OP_WIDTH-1:0] a, input logic [OP_WIDTH-1:0] b,
                                input int edges);
        logic [PROD_WIDTH-1:0] exp;
        exp = signed_product(a, b);
        n_checks = n_checks + 2;
        assert (product === exp) else begin
            err_product++;
            $display("FAIL %0t product exp %04h act %04h (%0d x %0d)", $time, exp, product,
                     $signed(a), $signed(b));
        end
        assert (edges == OP_WIDTH + 1) else begin
            err_done++;
            $display("FAIL %0t done latency exp %0d act %0d", $time, OP_WIDTH + 1, edges);
        end
    endtask

    // One complete multiplication
    task automatic multiply(input logic [OP_WIDTH-1:0] a, input logic [OP_WIDTH-1:0] b);
        int edges;
        bit seen;
        issue_start(a, b);
        wait_done(edges, seen);
        if (seen) begin
            check_result(a, b, edges);
        end
    endtask

    // Second start while busy must change nothing
    task automatic multiply_with_restart(input logic [OP_WIDTH-1:0] a,
                                         input logic [OP_WIDTH-1:0] b);
        int edges;
        bit seen;
        issue_start(a, b);
        repeat (3) begin
            @(posedge clk);
            #2;
        end
        start        = 1'b1;                     // Mid-run start with new operands
        multiplicand = ~a;
        multiplier   = b ^ 8'h3c;
        n_checks++;
        assert (busy === 1'b1) else begin
            err_busy++;
            $display("FAIL %0t busy exp 1 act %0b", $time, busy);
        end
        @(posedge clk);
        #2;
        start = 1'b0;
        wait_done(edges, seen);
        if (seen) begin
            check_result(a, b, edges + 4);       // Edges before the restart
        end
    endtask

    // Idle with changing inputs where product holds and done stays low
    task automatic hold_check(input int cycles);
        logic [PROD_WIDTH-1:0] held;
        held = product;
        repeat (cycles) begin
            @(posedge clk);
            #2;
            multiplicand = multiplicand + 8'd37;   // Noise on operand pins
            multiplier   = multiplier ^ 8'ha5;
            n_checks = n_checks + 2;
            assert (product === held) else begin
                err_product++;
                $display("FAIL %0t product exp %04h act %04h", $time, held, product);
            end
            assert (done === 1'b0) else begin
                err_done++;
                $display("FAIL %0t done exp 0 act %0b", $time, done);
            end
        end
    endtask

    initial begin
        int seed_dummy;
        int total;
        rst_n        = 1'b0;                     // Reset from time zero
        start        = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        seed_dummy   = $urandom(32'h7e47);       // Seed once

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (3) begin
            @(posedge clk);                      // Idle after reset
            #2;
        end

        multiply(8'd0, 8'd93);                   // 0 x x
        multiply(8'd1, 8'hff);                   // 1 x -1
        multiply(8'h80, 8'h80);                  // -128 x -128
        multiply(8'h80, 8'h7f);                  // -128 x 127
        multiply(8'h7f, 8'h7f);                  // 127 x 127
        multiply(8'h55, 8'haa);                  // Alternating bits exercise all opcodes
        multiply(8'haa, 8'h55);
        multiply(8'h33, 8'hcc);                  // Pairs of ones with pass steps

        multiply_with_restart(8'hd9, 8'h4b);     // Start ignored while busy
        hold_check(OP_WIDTH + 4);

        repeat (200) begin
            multiply(OP_WIDTH'($urandom()), OP_WIDTH'($urandom()));
        end
        hold_check(6);

        total = err_busy + err_done + err_product + err_timeout;
        $display("%0d mults %0d checks %0d errors: busy %0d done %0d product %0d timeout %0d",
                 n_mults, n_checks, total, err_busy, err_done, err_product, err_timeout);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : tb_booth_multiplier

`default_nettype wire
